// ==== verilog/agg_pkg.sv ====
/*
  aggregation package
  stream beat types, lane type, header beat counter
  and the destination MAC rewrite constants
*/

package agg_pkg;

  typedef logic [63:0]  data_t;    // one stream beat
  typedef logic [7:0]   keep_t;    // byte enables
  typedef logic [127:0] user_t;    // sideband metadata
  typedef logic [31:0]  lane_t;    // one aggregated value

  localparam int LANES = $bits(data_t) / $bits(lane_t);

  // payload starts at bit 320 of the packet
  localparam int HEADER_BEATS = 320 / $bits(data_t);

  typedef logic [2:0] hdr_cnt_t;   // header beat counter

  typedef logic [47:0] mac_t;

  // destination MAC position in beat 0
  localparam int DEST_MAC_LSB = 0;

  localparam mac_t NEW_DEST_MAC = 48'hffff_ffff_ffff;   // broadcast

endpackage

// ==== verilog/agg_stream_if.sv ====
/*
  stream interface for one flow of beats
  src modport drives payload and valid, snk drives ready
*/

`timescale 1ns/1ps

interface agg_stream_if
  import agg_pkg::*;
();

  data_t tdata;
  keep_t tkeep;
  user_t tuser;
  logic  tlast;
  logic  tvalid;
  logic  tready;   // from the sink

  modport src (output tdata, tkeep, tuser, tlast, tvalid, input tready);

  modport snk (input tdata, tkeep, tuser, tlast, tvalid, output tready);

endinterface

// ==== verilog/agg_input_fifo.sv ====
/*
  per-port input FIFO
  fall-through head, circular memory with fill count
  ready drops when fewer than four entries are free
*/

`timescale 1ns/1ps

module agg_input_fifo
  import agg_pkg::*;
#(
  parameter int DEPTH_BITS = 4
) (
  input logic         axis_aclk,
  input logic         axis_resetn,
  agg_stream_if.snk   wr,
  agg_stream_if.src   rd
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  data_t data_mem [DEPTH];
  keep_t keep_mem [DEPTH];
  user_t user_mem [DEPTH];
  logic  last_mem [DEPTH];

  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   fill;      // one extra bit so full is distinct from empty
  logic                  wr_en;
  logic                  rd_en;
  logic                  nearly_full;

  assign nearly_full = int'(fill) > DEPTH - 4;   // keeps room for beats in flight
  assign wr.tready   = ~nearly_full;
  assign wr_en       = wr.tvalid & wr.tready;

  assign rd.tvalid = (fill != '0);
  assign rd.tdata  = data_mem[rd_ptr];
  assign rd.tkeep  = keep_mem[rd_ptr];
  assign rd.tuser  = user_mem[rd_ptr];
  assign rd.tlast  = last_mem[rd_ptr];
  assign rd_en     = rd.tvalid & rd.tready;

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= wr.tdata;
      keep_mem[wr_ptr] <= wr.tkeep;
      user_mem[wr_ptr] <= wr.tuser;
      last_mem[wr_ptr] <= wr.tlast;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;   // both or neither
      endcase
    end
  end

endmodule

// ==== verilog/agg_beat_joiner.sv ====
/*
  beat joiner
  pops one beat from every port at once
  header beats forwarded from port 0 with the dest MAC rewritten
  payload beats summed lane by lane across all ports
*/

`timescale 1ns/1ps

module agg_beat_joiner
  import agg_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input logic         axis_aclk,
  input logic         axis_resetn,
  agg_stream_if.snk   in [NUM_PORTS],
  agg_stream_if.src   out
);

  localparam int LANE_W = $bits(lane_t);

  typedef enum logic {
    HEADER,
    PAYLOAD
  } join_state_t;

  join_state_t state;
  hdr_cnt_t    hdr_cnt;

  data_t                head_data [NUM_PORTS];
  logic [NUM_PORTS-1:0] head_valid;
  logic                 all_valid;
  logic                 master_last;
  logic                 xfer;
  data_t                hdr_data;
  data_t                sum_data;
  lane_t                lane_sum;

  // interface arrays need constant indices, so flatten the heads here
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    assign head_data[p]  = in[p].tdata;
    assign head_valid[p] = in[p].tvalid;
    assign in[p].tready  = all_valid & out.tready;   // pop all ports together
  end

  assign all_valid   = &head_valid;
  assign master_last = in[0].tlast;
  assign xfer        = all_valid & out.tready;

  // port 0 header beat, MAC replaced on the first beat only
  always_comb begin
    hdr_data = head_data[0];
    if (hdr_cnt == '0) begin
      hdr_data[DEST_MAC_LSB +: $bits(mac_t)] = NEW_DEST_MAC;
    end
  end

  // lane sums wrap modulo 2^32
  always_comb begin
    sum_data = '0;
    lane_sum = '0;
    for (int l = 0; l < LANES; l++) begin
      lane_sum = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        lane_sum = lane_sum + head_data[p][l*LANE_W +: LANE_W];
      end
      sum_data[l*LANE_W +: LANE_W] = lane_sum;
    end
  end

  assign out.tvalid = all_valid;
  assign out.tdata  = (state == HEADER) ? hdr_data : sum_data;
  assign out.tkeep  = in[0].tkeep;   // control fields follow the master
  assign out.tuser  = in[0].tuser;
  assign out.tlast  = master_last;

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      state   <= HEADER;
      hdr_cnt <= '0;
    end else if (xfer) begin
      if (master_last) begin
        state   <= HEADER;   // next round starts with a header
        hdr_cnt <= '0;
      end else if (state == HEADER) begin
        if (hdr_cnt == hdr_cnt_t'(HEADER_BEATS - 1)) begin
          state   <= PAYLOAD;
          hdr_cnt <= '0;
        end else begin
          hdr_cnt <= hdr_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== verilog/agg_output_reg.sv ====
/*
  output register stage
  one-beat valid/ready pipeline register
*/

`timescale 1ns/1ps

module agg_output_reg
  import agg_pkg::*;
(
  input logic         axis_aclk,
  input logic         axis_resetn,
  agg_stream_if.snk   in,
  agg_stream_if.src   out
);

  data_t data_q;
  keep_t keep_q;
  user_t user_q;
  logic  last_q;
  logic  valid_q;
  logic  load;

  // take a new beat when empty or when the held one leaves now
  assign in.tready = ~valid_q | out.tready;
  assign load      = in.tvalid & in.tready;

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out.tready) begin
      valid_q <= 1'b0;   // beat taken, nothing behind it
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (load) begin
      data_q <= in.tdata;
      keep_q <= in.tkeep;
      user_q <= in.tuser;
      last_q <= in.tlast;
    end
  end

  assign out.tvalid = valid_q;
  assign out.tdata  = data_q;
  assign out.tkeep  = keep_q;
  assign out.tuser  = user_q;
  assign out.tlast  = last_q;

endmodule

// ==== verilog/agg_top.sv ====
/*
  aggregation stage top level
  per-port input FIFOs, beat joiner and output register
*/

`timescale 1ns/1ps

module agg_top
  import agg_pkg::*;
#(
  parameter int NUM_PORTS       = 2,
  parameter int FIFO_DEPTH_BITS = 4
) (
  input  logic                 axis_aclk,
  input  logic                 axis_resetn,

  // input streams, one per port
  input  data_t [NUM_PORTS-1:0] s_tdata,
  input  keep_t [NUM_PORTS-1:0] s_tkeep,
  input  user_t [NUM_PORTS-1:0] s_tuser,
  input  logic  [NUM_PORTS-1:0] s_tlast,
  input  logic  [NUM_PORTS-1:0] s_tvalid,
  output logic  [NUM_PORTS-1:0] s_tready,

  // aggregated output stream
  output data_t                m_tdata,
  output keep_t                m_tkeep,
  output user_t                m_tuser,
  output logic                 m_tlast,
  output logic                 m_tvalid,
  input  logic                 m_tready
);

  agg_stream_if s_if    [NUM_PORTS] ();   // port side of each FIFO
  agg_stream_if fifo_if [NUM_PORTS] ();   // FIFO heads into the joiner
  agg_stream_if join_if ();
  agg_stream_if out_if ();

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    assign s_if[p].tdata  = s_tdata[p];
    assign s_if[p].tkeep  = s_tkeep[p];
    assign s_if[p].tuser  = s_tuser[p];
    assign s_if[p].tlast  = s_tlast[p];
    assign s_if[p].tvalid = s_tvalid[p];
    assign s_tready[p]    = s_if[p].tready;

    agg_input_fifo #(
      .DEPTH_BITS (FIFO_DEPTH_BITS)
    ) fifo_i (
      .axis_aclk   (axis_aclk),
      .axis_resetn (axis_resetn),
      .wr          (s_if[p]),
      .rd          (fifo_if[p])
    );
  end

  agg_beat_joiner #(
    .NUM_PORTS (NUM_PORTS)
  ) joiner_i (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .in          (fifo_if),
    .out         (join_if)
  );

  agg_output_reg out_reg_i (
    .axis_aclk   (axis_aclk),
    .axis_resetn (axis_resetn),
    .in          (join_if),
    .out         (out_if)
  );

  assign m_tdata       = out_if.tdata;
  assign m_tkeep       = out_if.tkeep;
  assign m_tuser       = out_if.tuser;
  assign m_tlast       = out_if.tlast;
  assign m_tvalid      = out_if.tvalid;
  assign out_if.tready = m_tready;

endmodule

// ==== verif/agg_tb.sv ====
/*
  directed testbench for the aggregation stage
  clock, reset, LFSR, per-port drivers, output monitor,
  reference model, compare tasks, tests and watchdog
*/

`timescale 1ns/1ps

module agg_tb
  import agg_pkg::*;
;

  typedef struct packed {
    data_t data;
    keep_t keep;
    user_t user;
    logic  last;
  } beat_t;

  localparam int TOTAL_BEATS = 8 + 12 + 3 * 8 + 10 + 6 + 9 + 7;   // beats per port, all tests

  logic axis_aclk = 1'b0;
  logic axis_resetn;
  data_t [1:0] s_tdata;
  keep_t [1:0] s_tkeep;
  user_t [1:0] s_tuser;
  logic  [1:0] s_tlast, s_tvalid, s_tready;
  data_t m_tdata;
  keep_t m_tkeep;
  user_t m_tuser;
  logic  m_tlast, m_tvalid, m_tready;

  logic [31:0] lfsr = 32'h7fee_7385;
  beat_t port_q [2][$];
  beat_t exp_q [$];
  beat_t got_q [$];
  int    delay [2] = '{0, 0};      // start skew in cycles
  bit    stall_en [2] = '{0, 0};
  bit    bp_en = 1'b0;             // random m_tready
  int    acc_cnt [2] = '{0, 0};
  int    out_cnt = 0;
  int    err_cnt = 0;
  int    err_base = 0;
  int    test_cnt = 0;

  agg_top #(.NUM_PORTS(2), .FIFO_DEPTH_BITS(4)) dut_i (.*);

  always #10 axis_aclk = ~axis_aclk;

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : (lfsr >> 1);   // galois step
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  for (genvar p = 0; p < 2; p++) begin : g_drv
    always begin
      logic fire;
      @(negedge axis_aclk);
      fire = s_tvalid[p] & s_tready[p];   // transfers on the coming edge
      @(posedge axis_aclk);
      #2;
      if (fire) begin
        void'(port_q[p].pop_front());
        acc_cnt[p]++;
      end
      if (delay[p] > 0) delay[p]--;
      if (!s_tvalid[p] || fire) begin   // a presented beat stays until taken
        s_tvalid[p] = 1'b0;
        if (port_q[p].size() > 0 && delay[p] == 0 && !(stall_en[p] && rand_bits(2) == 0)) begin
          s_tvalid[p] = 1'b1;
          {s_tdata[p], s_tkeep[p], s_tuser[p], s_tlast[p]} = port_q[p][0];
        end
      end
    end
  end

  always begin
    @(posedge axis_aclk);
    #2 m_tready = bp_en ? rand_bits(1) : 1'b1;
  end

  // output monitor
  always @(negedge axis_aclk) begin
    if (m_tvalid && m_tready) begin
      if (out_cnt >= acc_cnt[0] || out_cnt >= acc_cnt[1]) begin
        $display("[FAIL] %0t ns: output beat %0d before both ports supplied it", $time, out_cnt);
        err_cnt++;
      end
      got_q.push_back({m_tdata, m_tkeep, m_tuser, m_tlast});
      out_cnt++;
    end
  end

  task automatic check_beat(data_t got, data_t exp, string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s tdata %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_keep(keep_t got, keep_t exp, string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s tkeep %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_user(user_t got, user_t exp, string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s tuser %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_last(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // reference model with header from port 0 and payload lanes summed mod 2^32
  task automatic make_packet(int len, bit near_wrap);
    beat_t b [2];
    beat_t e;
    lane_t sum;
    for (int i = 0; i < len; i++) begin
      for (int p = 0; p < 2; p++) begin
        b[p].data = rand_bits(64);
        if (near_wrap && i >= 5) b[p].data = b[p].data | 64'hffff_ff00_ffff_ff00;
        b[p].keep = rand_bits(8);
        b[p].user = {rand_bits(64), rand_bits(64)};
        b[p].last = (i == len - 1);
        port_q[p].push_back(b[p]);
      end
      e = b[0];
      if (i == 0) e.data[47:0] = 48'hffff_ffff_ffff;   // dest MAC rewrite
      if (i >= 5) begin
        for (int l = 0; l < 2; l++) begin
          sum = b[0].data[l*32 +: 32] + b[1].data[l*32 +: 32];
          e.data[l*32 +: 32] = sum;
        end
      end
      exp_q.push_back(e);
    end
  endtask

  task automatic finish_test(string name);
    string what;
    wait (got_q.size() >= exp_q.size());
    repeat (10) @(posedge axis_aclk);   // catch duplicated beats
    if (got_q.size() != exp_q.size()) begin
      $display("%s: got %0d output beats instead of %0d", name, got_q.size(), exp_q.size());
      err_cnt++;
    end
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
      what = $sformatf("%s beat %0d", name, i);
      check_beat(got_q[i].data, exp_q[i].data, what);
      check_keep(got_q[i].keep, exp_q[i].keep, what);
      check_user(got_q[i].user, exp_q[i].user, what);
      check_last(got_q[i].last, exp_q[i].last, {what, " tlast"});
    end
    got_q.delete();
    exp_q.delete();
    test_cnt++;
    $display("%s: %0d errors", name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  task automatic test_reset();
    @(posedge axis_aclk);
    #2;
    check_last(m_tvalid, 1'b0, "m_tvalid after reset");
    check_last(&s_tready, 1'b1, "s_tready after reset");
    finish_test("reset");
  endtask

  task automatic test_header();
    make_packet(8, 1'b0);
    finish_test("header forwarding");
  endtask

  task automatic test_payload();
    make_packet(12, 1'b1);
    finish_test("payload sum");
  endtask

  task automatic test_backpressure();
    bp_en = 1'b1;
    repeat (3) make_packet(8, 1'b0);
    finish_test("back-pressure");
    bp_en = 1'b0;
  endtask

  task automatic test_skew();
    delay[1] = 6;
    stall_en[1] = 1'b1;
    make_packet(10, 1'b1);
    finish_test("port skew");
    stall_en[1] = 1'b0;
  endtask

  task automatic test_rounds();
    make_packet(6, 1'b0);
    make_packet(9, 1'b0);
    make_packet(7, 1'b1);
    finish_test("back-to-back rounds");
  endtask

  initial begin
    axis_resetn = 1'b0;
    s_tdata = '0;
    s_tkeep = '0;
    s_tuser = '0;
    s_tlast = '0;
    s_tvalid = '0;
    m_tready = 1'b1;
    repeat (16) @(posedge axis_aclk);
    #2 axis_resetn = 1'b1;
    test_reset();
    test_header();
    test_payload();
    test_backpressure();
    test_skew();
    test_rounds();
    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #((TOTAL_BEATS * 40 + 16) * 20);
    $display("run timed out waiting for output beats");
    $display("tests failed");
    $finish;
  end

endmodule

// ==== build.f ====
verilog/agg_pkg.sv
verilog/agg_stream_if.sv
verilog/agg_input_fifo.sv
verilog/agg_beat_joiner.sv
verilog/agg_output_reg.sv
verilog/agg_top.sv
verif/agg_tb.sv

// ==== Bender.yml ====
package:
  name: agg

sources:
  - verilog/agg_pkg.sv
  - verilog/agg_stream_if.sv
  - verilog/agg_input_fifo.sv
  - verilog/agg_beat_joiner.sv
  - verilog/agg_output_reg.sv
  - verilog/agg_top.sv
  - target: simulation
    files:
      - verif/agg_tb.sv
